// ==== source/rv_track_pkg.sv ====
`default_nettype none

package rv_track_pkg;

    // Widths with a meaning of their own
    typedef logic [31:0] inst_t;
    typedef logic [31:0] pc_t;
    typedef logic [31:0] imm_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // Major opcodes of RV32I, bits 6:0 of the word
    typedef enum logic [6:0] {
        OPC_R     = 7'b0110011, // Register-register ALU
        OPC_I     = 7'b0010011, // OP-IMM incl. shifts
        OPC_IL    = 7'b0000011, // Loads
        OPC_JALR  = 7'b1100111,
        OPC_S     = 7'b0100011, // Stores
        OPC_B     = 7'b1100011, // Conditional branches
        OPC_JAL   = 7'b1101111,
        OPC_LUI   = 7'b0110111,
        OPC_AUIPC = 7'b0010111,
        OPC_FENCE = 7'b0001111, // FENCE, FENCE.TSO, PAUSE
        OPC_E     = 7'b1110011  // ECALL, EBREAK
    } opcode_t;

    // ADDI x0, x0, 0
    localparam inst_t NOP_INST = 32'h0000_0013;

    localparam pc_t PC_RESET = 32'h0000_0000;

    // IF, PD, ID, EX, MEM, WB
    localparam int NUM_STAGES = 6;

endpackage

`default_nettype wire

// ==== source/rv_legality_check.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_legality_check (
    input  rv_track_pkg::inst_t inst_i,
    output logic                illegal_o
);
    import rv_track_pkg::*;

    // funct7 of SUB, SRA and SRAI
    localparam funct7_t F7_ALT  = 7'b0100000;
    localparam funct7_t F7_BASE = 7'b0000000;

    opcode_t   opcode;
    funct3_t   funct3;
    funct7_t   funct7;
    logic [1:0] jal_align;
    logic [1:0] jalr_align;
    logic [1:0] br_align;
    logic      legal;

    assign opcode = opcode_t'(inst_i[6:0]);
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    // Low bits of the target offsets
    assign jal_align  = {inst_i[21], 1'b0};  // J imm bit 1 lives at inst[21]
    assign jalr_align = inst_i[21:20];
    assign br_align   = {inst_i[8], 1'b0};   // B imm bit 1 lives at inst[8]

    always_comb begin
        legal = 1'b0;
        case (opcode)
            OPC_LUI, OPC_AUIPC: begin
                legal = 1'b1;
            end
            OPC_JAL: begin
                legal = (jal_align == 2'b00);
            end
            OPC_JALR: begin
                legal = (funct3 == 3'b000) && (jalr_align == 2'b00);
            end
            OPC_B: begin
                // 010 and 011 are unassigned branch encodings
                legal = (funct3 != 3'b010) && (funct3 != 3'b011) && (br_align == 2'b00);
            end
            OPC_IL: begin
                legal = (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101});
            end
            OPC_S: begin
                legal = (funct3 inside {3'b000, 3'b001, 3'b010});
            end
            OPC_I: begin
                if (funct3 == 3'b001) begin
                    legal = (funct7 == F7_BASE);                          // SLLI
                end else if (funct3 == 3'b101) begin
                    legal = (funct7 == F7_BASE) || (funct7 == F7_ALT);    // SRLI, SRAI
                end else begin
                    legal = 1'b1;
                end
            end
            OPC_R: begin
                if (funct7 == F7_BASE) begin
                    legal = 1'b1;
                end else begin
                    // Only SUB and SRA take the alternate funct7
                    legal = (funct7 == F7_ALT) && ((funct3 == 3'b000) || (funct3 == 3'b101));
                end
            end
            OPC_FENCE: begin
                legal = (funct3 == 3'b000);
            end
            OPC_E: begin
                // ECALL or EBREAK with all other fields zero
                legal = (inst_i[19:7] == 13'd0) &&
                        ((inst_i[31:20] == 12'd0) || (inst_i[31:20] == 12'd1));
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    assign illegal_o = ~legal;

endmodule

`default_nettype wire

// ==== source/rv_imm_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_imm_gen (
    input  rv_track_pkg::inst_t inst_i,
    output rv_track_pkg::imm_t  imm_o
);
    import rv_track_pkg::*;

    opcode_t opcode;
    imm_t    imm_i_type;
    imm_t    imm_s_type;
    imm_t    imm_b_type;
    imm_t    imm_j_type;
    imm_t    imm_u_type;

    assign opcode = opcode_t'(inst_i[6:0]);

    // All formats sign-extend from bit 31
    assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s_type = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b_type = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                         inst_i[11:8], 1'b0};
    assign imm_j_type = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                         inst_i[30:21], 1'b0};
    assign imm_u_type = {inst_i[31:12], 12'd0};

    always_comb begin
        case (opcode)
            OPC_I, OPC_IL, OPC_JALR, OPC_E: imm_o = imm_i_type;
            OPC_S:                          imm_o = imm_s_type;
            OPC_B:                          imm_o = imm_b_type;
            OPC_JAL:                        imm_o = imm_j_type;
            OPC_LUI, OPC_AUIPC:             imm_o = imm_u_type;
            default:                        imm_o = '0; // OP, FENCE, unknown
        endcase
    end

endmodule

`default_nettype wire

// ==== source/pipe_follower.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_follower #(
    parameter rv_track_pkg::pc_t PC_RESET = rv_track_pkg::PC_RESET
) (
    input  logic                clk,
    input  logic                rst,
    input  rv_track_pkg::inst_t inst_i,
    input  rv_track_pkg::pc_t   pc_i,
    input  logic                valid_i,
    input  logic                illegal_i,
    input  logic                pd_stall_i,
    input  logic                id_stall_i,
    input  logic                ex_stall_i,
    input  logic                wb_stall_i,
    input  logic                pd_flush_i,
    input  logic                bu_flush_i,
    output rv_track_pkg::inst_t wb_inst_o,
    output rv_track_pkg::pc_t   wb_pc_o,
    output logic                wb_bubble_o,
    output logic                wb_retire_o
);
    import rv_track_pkg::*;

    inst_t if_inst, pd_inst, id_inst, ex_inst, mem_inst, wb_inst;
    pc_t   if_pc, pd_pc, id_pc, ex_pc, mem_pc, wb_pc;
    logic  if_bubble, pd_bubble, ex_bubble, mem_bubble, wb_bubble;
    logic  id_bubble_r;
    logic  id_bubble;   // Visible ID bubble
    logic  retire;

    // IF, held by pd_stall
    always_ff @(posedge clk) begin
        if (rst) begin
            if_inst   <= NOP_INST;
            if_pc     <= PC_RESET;
            if_bubble <= 1'b1;
        end else begin
            if (!pd_stall_i) begin
                if_inst <= inst_i;
                if_pc   <= pc_i;
            end
            if (pd_flush_i) begin
                if_bubble <= 1'b1;
            end else if (!pd_stall_i) begin
                if_bubble <= ~valid_i | illegal_i; // No fetch or bad word
            end
        end
    end

    // PD, held by id_stall
    always_ff @(posedge clk) begin
        if (rst) begin
            pd_inst   <= NOP_INST;
            pd_pc     <= PC_RESET;
            pd_bubble <= 1'b1;
        end else begin
            if (!id_stall_i) begin
                pd_inst <= if_inst;
                pd_pc   <= if_pc;
            end
            if (bu_flush_i) begin
                pd_bubble <= 1'b1;
            end else if (!id_stall_i) begin
                pd_bubble <= if_bubble;
            end
        end
    end

    // ID, held by ex_stall
    always_ff @(posedge clk) begin
        if (rst) begin
            id_inst     <= NOP_INST;
            id_pc       <= PC_RESET;
            id_bubble_r <= 1'b1;
        end else begin
            if (!ex_stall_i) begin
                id_inst <= pd_inst;
                id_pc   <= pd_pc;
            end
            if (bu_flush_i) begin
                id_bubble_r <= 1'b1;
            end else if (!ex_stall_i) begin
                id_bubble_r <= pd_bubble | id_stall_i; // Decode hold inserts a bubble
            end
        end
    end

    // A stalled or flushed ID never hands a live instruction to EX
    assign id_bubble = id_bubble_r | ex_stall_i | bu_flush_i;

    // EX
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_inst   <= NOP_INST;
            ex_pc     <= PC_RESET;
            ex_bubble <= 1'b1;
        end else if (!ex_stall_i) begin
            ex_inst   <= id_inst;
            ex_pc     <= id_pc;
            ex_bubble <= id_bubble;
        end
    end

    // MEM and WB move together under wb_stall
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_inst   <= NOP_INST;
            mem_pc     <= PC_RESET;
            mem_bubble <= 1'b1;
            wb_inst    <= NOP_INST;
            wb_pc      <= PC_RESET;
            wb_bubble  <= 1'b1;
        end else if (!wb_stall_i) begin
            mem_inst   <= ex_inst;
            mem_pc     <= ex_pc;
            mem_bubble <= ex_bubble;
            wb_inst    <= mem_inst;
            wb_pc      <= mem_pc;
            wb_bubble  <= mem_bubble;
        end
    end

    // Pulses only on a fresh load, so a held WB retires once
    always_ff @(posedge clk) begin
        if (rst) begin
            retire <= 1'b0;
        end else begin
            retire <= ~wb_stall_i & ~mem_bubble;
        end
    end

    assign wb_inst_o   = wb_inst;
    assign wb_pc_o     = wb_pc;
    assign wb_bubble_o = wb_bubble;
    assign wb_retire_o = retire;

endmodule

`default_nettype wire

// ==== source/rv_pipe_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_pipe_tracker #(
    parameter rv_track_pkg::pc_t PC_RESET = rv_track_pkg::PC_RESET
) (
    input  logic                clk,
    input  logic                rst,
    input  rv_track_pkg::inst_t fetch_inst_i,
    input  rv_track_pkg::pc_t   fetch_pc_i,
    input  logic                fetch_valid_i,
    input  logic                pd_stall_i,
    input  logic                id_stall_i,
    input  logic                ex_stall_i,
    input  logic                wb_stall_i,
    input  logic                pd_flush_i,
    input  logic                bu_flush_i,
    output logic                fetch_illegal_o,
    output rv_track_pkg::inst_t wb_inst_o,
    output rv_track_pkg::pc_t   wb_pc_o,
    output rv_track_pkg::imm_t  wb_imm_o,
    output logic                wb_bubble_o,
    output logic                wb_retire_o
);

    logic illegal; // Checker verdict on the fetched word

    rv_legality_check u_legality (
        .inst_i    (fetch_inst_i),
        .illegal_o (illegal)
    );

    assign fetch_illegal_o = illegal;

    pipe_follower #(
        .PC_RESET (PC_RESET)
    ) u_follower (
        .clk         (clk),
        .rst         (rst),
        .inst_i      (fetch_inst_i),
        .pc_i        (fetch_pc_i),
        .valid_i     (fetch_valid_i),
        .illegal_i   (illegal),
        .pd_stall_i  (pd_stall_i),
        .id_stall_i  (id_stall_i),
        .ex_stall_i  (ex_stall_i),
        .wb_stall_i  (wb_stall_i),
        .pd_flush_i  (pd_flush_i),
        .bu_flush_i  (bu_flush_i),
        .wb_inst_o   (wb_inst_o),
        .wb_pc_o     (wb_pc_o),
        .wb_bubble_o (wb_bubble_o),
        .wb_retire_o (wb_retire_o)
    );

    // Immediate of whatever sits in WB
    rv_imm_gen u_imm_gen (
        .inst_i (wb_inst_o),
        .imm_o  (wb_imm_o)
    );

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 50,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    // Released on a falling edge, well away from the sampling edge
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== test/pipe_follower_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_follower_assertions (
    input logic                clk_i,
    input logic                rst_i,
    input logic                wb_stall_i,
    input logic                bu_flush_i,
    input logic                pd_bubble_i,
    input rv_track_pkg::inst_t wb_inst_i,
    input rv_track_pkg::pc_t   wb_pc_i,
    input logic                wb_bubble_i
);

    // WB starts out empty
    a_reset_bubble: assert property (@(posedge clk_i) rst_i |=> wb_bubble_i)
        else $error("WB bubble low after reset");

    a_wb_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        wb_stall_i |=> $stable(wb_inst_i) && $stable(wb_pc_i) && $stable(wb_bubble_i))
        else $error("WB contents moved while wb_stall was high");

    a_flush_pd: assert property (@(posedge clk_i) disable iff (rst_i)
        bu_flush_i |=> pd_bubble_i)  // Branch flush kills the PD slot
        else $error("PD bubble low after bu_flush");

endmodule

bind pipe_follower pipe_follower_assertions u_follower_assertions (
    .clk_i       (clk),
    .rst_i       (rst),
    .wb_stall_i  (wb_stall_i),
    .bu_flush_i  (bu_flush_i),
    .pd_bubble_i (pd_bubble),
    .wb_inst_i   (wb_inst),
    .wb_pc_i     (wb_pc),
    .wb_bubble_i (wb_bubble)
);

`default_nettype wire

// ==== test/tb_rv_pipe_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv_pipe_tracker;
    import rv_track_pkg::*;

    localparam int NUM_WORDS  = 16;
    localparam int NUM_RANDOM = 60;
    localparam int WB         = NUM_STAGES - 1;

    // Bit 32 set where the checker must flag the word
    localparam logic [32:0] WORDS [NUM_WORDS] = '{
        {1'b0, 32'h0050_0093},  // ADDI x1, x0, 5
        {1'b0, 32'h1234_5137},  // LUI x2, 0x12345
        {1'b0, 32'h0000_1197},  // AUIPC x3, 1
        {1'b0, 32'hFF9F_F0EF},  // JAL x1, -8
        {1'b0, 32'h0001_00E7},  // JALR x1, 0(x2)
        {1'b0, 32'hFE20_88E3},  // BEQ x1, x2, -16
        {1'b0, 32'hFFC0_A283},  // LW x5, -4(x1)
        {1'b0, 32'hFE50_AA23},  // SW x5, -12(x1)
        {1'b0, 32'h4030_D093},  // SRAI x1, x1, 3
        {1'b0, 32'h4020_81B3},  // SUB x3, x1, x2
        {1'b0, 32'h0FF0_000F},  // FENCE
        {1'b0, 32'h0010_0073},  // EBREAK
        {1'b1, 32'h0200_9093},  // SLLI with funct7 1
        {1'b1, 32'h0020_A863},  // Branch funct3 010
        {1'b1, 32'h0020_0073},  // SYSTEM with imm 2
        {1'b1, 32'h0000_0000}
    };

    typedef struct packed {
        inst_t      inst;
        pc_t        pc;
        logic       valid;
        logic [3:0] stalls;   // pd, id, ex, wb
        logic [1:0] flushes;  // pd, bu
        logic       illegal;
    } row_t;

    logic        clk, rst;
    inst_t       fetch_inst, wb_inst;
    pc_t         fetch_pc, wb_pc, next_pc;
    imm_t        wb_imm;
    logic        fetch_valid, fetch_illegal, exp_illegal;
    logic        pd_stall, id_stall, ex_stall, wb_stall, pd_flush, bu_flush;
    logic        wb_bubble, wb_retire;
    logic [31:0] rng;
    row_t        table_q[$];
    int          cycle_count, cycle_limit;

    // Expected stage contents with IF at index 0
    inst_t       m_inst [NUM_STAGES];
    pc_t         m_pc [NUM_STAGES];
    logic        m_bub [NUM_STAGES];
    logic        m_retire;
    logic        id_visible;

    tb_clock_gen u_clock (
        .clk_o (clk),
        .rst_o (rst)
    );

    rv_pipe_tracker #(
        .PC_RESET (PC_RESET)
    ) dut (
        .clk             (clk),
        .rst             (rst),
        .fetch_inst_i    (fetch_inst),
        .fetch_pc_i      (fetch_pc),
        .fetch_valid_i   (fetch_valid),
        .pd_stall_i      (pd_stall),
        .id_stall_i      (id_stall),
        .ex_stall_i      (ex_stall),
        .wb_stall_i      (wb_stall),
        .pd_flush_i      (pd_flush),
        .bu_flush_i      (bu_flush),
        .fetch_illegal_o (fetch_illegal),
        .wb_inst_o       (wb_inst),
        .wb_pc_o         (wb_pc),
        .wb_imm_o        (wb_imm),
        .wb_bubble_o     (wb_bubble),
        .wb_retire_o     (wb_retire)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic imm_t expected_imm(input inst_t w);
        imm_t sext;
        sext = $signed(w) >>> 20;  // I immediate
        case (opcode_t'(w[6:0]))
            OPC_I, OPC_IL, OPC_JALR, OPC_E: return sext;
            OPC_S:              return {sext[31:5], w[11:7]};
            OPC_B:              return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            OPC_JAL:            return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            OPC_LUI, OPC_AUIPC: return w & 32'hFFFF_F000;
            default:            return '0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at time %0t: %s is %h, expected %h",
                     $time, name, actual, expected);
            $display("*** FAILED ***");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    task automatic add_row(input int idx, input logic valid, input logic [3:0] stalls,
                           input logic [1:0] flushes);
        row_t row;
        row.inst    = WORDS[idx][31:0];
        row.pc      = next_pc;
        row.valid   = valid;
        row.stalls  = stalls;
        row.flushes = flushes;
        row.illegal = WORDS[idx][32];
        table_q.push_back(row);
        next_pc = next_pc + 32'd4;
    endtask

    // Stage model stepped on the same edge as the DUT
    always @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < NUM_STAGES; s++) begin
                m_inst[s] = NOP_INST;
                m_pc[s]   = PC_RESET;
                m_bub[s]  = 1'b1;
            end
            m_retire = 1'b0;
        end else begin
            id_visible = m_bub[2] | ex_stall | bu_flush;
            m_retire   = ~wb_stall & ~m_bub[4];
            // From WB back to IF so each stage still sees the old upstream value
            if (!wb_stall) begin
                for (int s = WB; s > 3; s--) begin
                    m_inst[s] = m_inst[s - 1];
                    m_pc[s]   = m_pc[s - 1];
                    m_bub[s]  = m_bub[s - 1];
                end
            end
            if (!ex_stall) begin
                m_inst[3] = m_inst[2];
                m_pc[3]   = m_pc[2];
                m_bub[3]  = id_visible;
                m_inst[2] = m_inst[1];
                m_pc[2]   = m_pc[1];
                m_bub[2]  = m_bub[1] | id_stall;
            end
            if (!id_stall) begin
                m_inst[1] = m_inst[0];
                m_pc[1]   = m_pc[0];
                m_bub[1]  = m_bub[0];
            end
            if (bu_flush) begin
                m_bub[1] = 1'b1;
                m_bub[2] = 1'b1;
            end
            if (!pd_stall) begin
                m_inst[0] = fetch_inst;
                m_pc[0]   = fetch_pc;
                m_bub[0]  = ~fetch_valid | exp_illegal;
            end
            if (pd_flush) begin
                m_bub[0] = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the table did not finish within %0d cycles", cycle_limit);
            $display("*** FAILED ***");
            $fatal(1, "Cycle limit reached");
        end
    end

    initial begin
        logic [31:0] r;
        fetch_inst  = NOP_INST;
        fetch_pc    = PC_RESET;
        fetch_valid = 1'b0;
        exp_illegal = 1'b0;
        {pd_stall, id_stall, ex_stall, wb_stall, pd_flush, bu_flush} = '0;
        rng     = 32'd78231;
        next_pc = 32'h0000_1000;

        // Clean stream of legal words followed by the illegal ones
        for (int k = 0; k < NUM_WORDS; k++) begin
            add_row(k, 1'b1, 4'b0000, 2'b00);
        end
        add_row(0, 1'b0, 4'b0000, 2'b00);      // Nothing fetched
        add_row(1, 1'b0, 4'b0000, 2'b00);
        for (int k = 2; k < 5; k++) begin
            add_row(k, 1'b1, 4'b0001, 2'b00);  // WB held
        end
        add_row(6, 1'b1, 4'b0000, 2'b01);
        for (int k = 0; k < NUM_RANDOM; k++) begin
            rng = xorshift32(rng);
            r   = rng;
            add_row(int'(r % NUM_WORDS), r[10:8] != 3'd0,
                    {r[13:11] == 3'd0, r[16:14] == 3'd0, r[19:17] == 3'd0, r[21:20] == 2'd0},
                    {r[25:22] == 4'd0, r[29:26] == 4'd0});
        end
        for (int k = 0; k <= NUM_STAGES; k++) begin
            add_row(0, 1'b0, 4'b0000, 2'b00);  // Drain
        end
        cycle_limit = table_q.size() + NUM_STAGES + 20;

        wait (rst == 1'b0);
        for (int i = 0; i <= table_q.size(); i++) begin
            @(negedge clk);
            check_value("wb_inst_o", wb_inst, m_inst[WB]);
            check_value("wb_pc_o", wb_pc, m_pc[WB]);
            check_value("wb_bubble_o", 32'(wb_bubble), 32'(m_bub[WB]));
            check_value("wb_retire_o", 32'(wb_retire), 32'(m_retire));
            if (m_retire) begin
                check_value("wb_imm_o", wb_imm, expected_imm(m_inst[WB]));
            end
            if (i > 0) begin
                check_value("fetch_illegal_o", 32'(fetch_illegal), 32'(exp_illegal));
            end
            if (i < table_q.size()) begin
                fetch_inst  = table_q[i].inst;
                fetch_pc    = table_q[i].pc;
                fetch_valid = table_q[i].valid;
                exp_illegal = table_q[i].illegal;
                {pd_stall, id_stall, ex_stall, wb_stall} = table_q[i].stalls;
                {pd_flush, bu_flush} = table_q[i].flushes;
            end
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
source/rv_track_pkg.sv
source/rv_legality_check.sv
source/rv_imm_gen.sv
source/pipe_follower.sv
source/rv_pipe_tracker.sv
test/tb_clock_gen.sv
test/pipe_follower_assertions.sv
test/tb_rv_pipe_tracker.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the pipeline tracker testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_rv_pipe_tracker -f sources.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_rv_pipe_tracker
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi
exit 0
